// File: flist.f
logic/decode_pkg.sv
logic/op_classifier.sv
logic/yz_operand_decoder.sv
logic/local_count.sv
logic/dispatch_fsm.sv
logic/inst_decoder.sv
test/decode_checker.sv
test/tb_inst_decoder.sv

// File: logic/decode_pkg.sv
// shared definitions for the MMIX dispatch-stage decoder
// opcode and internal-op enums, operand flag masks, ring size
// operand spec, destination, fetch and control word structs
// register rule helper used for Y, Z and X operands
package decode_pkg;

	localparam int lring_size = 256;                       // local register ring entries
	localparam logic [7:0] lring_mask = 8'(lring_size - 1); // wraps ring addresses

	typedef logic [7:0] flags_t;

	// operand flag masks, one bit each
	localparam flags_t z_imm_bit    = 8'h01;
	localparam flags_t z_reg_bit    = 8'h02;
	localparam flags_t y_imm_bit    = 8'h04;
	localparam flags_t y_reg_bit    = 8'h08;
	localparam flags_t x_src_bit    = 8'h10;
	localparam flags_t x_dest_bit   = 8'h20;
	localparam flags_t rel_addr_bit = 8'h40; // YZ or XYZ is a relative address

	// kept opcodes, group bounds named where the classifier needs them
	typedef enum logic [7:0] {
		op_trap  = 8'h00,
		op_add   = 8'h20, op_addi  = 8'h21, op_addu = 8'h22, op_addui = 8'h23,
		op_sub   = 8'h24, op_subi  = 8'h25, op_subu = 8'h26, op_subui = 8'h27,
		op_cmp   = 8'h30, op_cmpi  = 8'h31, op_cmpu = 8'h32, op_cmpui = 8'h33,
		op_neg   = 8'h34, op_negi  = 8'h35, op_negu = 8'h36, op_negui = 8'h37,
		op_sl    = 8'h38, op_sli   = 8'h39, op_slu  = 8'h3a, op_slui  = 8'h3b,
		op_sr    = 8'h3c, op_sri   = 8'h3d, op_sru  = 8'h3e, op_srui  = 8'h3f,
		op_bn    = 8'h40, op_bevb  = 8'h4f,  // BN .. BEVB
		op_pbn   = 8'h50, op_pbevb = 8'h5f,  // PBN .. PBEVB
		op_or    = 8'hc0, op_nxori = 8'hcf,  // OR .. NXORI
		op_seth  = 8'he0, op_setl  = 8'he3,
		op_inch  = 8'he4, op_incl  = 8'he7,
		op_orh   = 8'he8, op_orl   = 8'heb,
		op_andnh = 8'hec, op_andnl = 8'hef,
		op_jmp   = 8'hf0, op_jmpb  = 8'hf1
	} mmix_opcode;

	typedef enum logic [4:0] {
		trap, add, addu, sub, subu, cmp, cmpu, shl, shlu, shr, shru,
		br, pbr, set, or_, orn, nor_, xor_, and_, andn, nand_, nxor,
		jmp, incrl
	} internal_op_t;

	typedef enum logic [1:0] {
		src_none   = 2'd0, // constant held in value
		src_global = 2'd1,
		src_local  = 2'd2
	} src_kind_t;

	typedef struct packed {
		logic [63:0] value;
		src_kind_t   kind;
		logic [7:0]  addr;
	} spec_t;

	typedef struct packed {
		logic       ren;  // register gets renamed
		src_kind_t  kind;
		logic [7:0] addr;
	} dest_t;

	typedef struct packed {
		logic [63:0] loc;
		logic [31:0] inst;
	} fetch_t;

	typedef struct packed {
		logic [63:0]  loc;
		internal_op_t i;
		logic         interim; // inserted word, not from the fetch
		dest_t        x;
		spec_t        b;       // X as a source
		spec_t        y;
		spec_t        z;
	} control_t;

	typedef enum logic [1:0] {st_idle, st_full, st_grow} fsm_state_t;

	// global at or above rG, local below rL, marginal reads as zero
	function automatic spec_t reg_spec(input logic [7:0] r, input logic [7:0] g,
		input logic [7:0] l, input logic [7:0] o);
		spec_t s;
		s = '0;
		if (r >= g) begin
			s.kind = src_global;
			s.addr = r;
		end else if (r < l) begin
			s.kind = src_local;
			s.addr = (o + r) & lring_mask; // wraps on the ring
		end
		return s;
	endfunction

endpackage

// File: logic/dispatch_fsm.sv
// dispatch state machine and output control register
// decides between incrl insertion and the real word
// valid/ready on both sides at one word per cycle when unstalled
`timescale 1ns/1ps

module dispatch_fsm
	import decode_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  fetch_t       head,
	input  logic         in_valid,
	output logic         in_ready,
	input  internal_op_t i,
	input  flags_t       f,
	input  spec_t        y,
	input  spec_t        z,
	input  logic [7:0]   g,
	input  logic [7:0]   l,
	input  logic [7:0]   o,
	output logic         grow,
	output control_t     ctl,
	output logic         out_valid,
	input  logic         out_ready
);

	fsm_state_t state;
	logic       up;       // high from the first cycle out of reset
	logic [7:0] xx;
	spec_t      x_spec;   // X through the register rule
	logic       marginal; // l <= X < g needs an incrl first
	logic       can_load; // slot empty or draining this edge
	logic       load;
	control_t   word;

	assign xx       = head.inst[23:16];
	assign x_spec   = reg_spec(xx, g, l, o);
	assign marginal = in_valid && ((f & x_dest_bit) != '0) && (xx >= l) && (xx < g);

	assign out_valid = state != st_idle;
	assign can_load  = up && (!out_valid || out_ready);
	assign load      = can_load && in_valid;
	assign grow      = load && marginal;
	assign in_ready  = can_load && !marginal; // fetch held while incrls go out

	always_comb begin
		word     = '0;
		word.loc = head.loc;
		if (marginal) begin
			word.i       = incrl;
			word.interim = 1'b1;
			word.x.ren   = 1'b1;
			word.x.kind  = src_local;
			word.x.addr  = (o + l) & lring_mask; // next ring slot
		end else begin
			word.i = i;
			if ((f & x_dest_bit) != '0) begin
				word.x.ren  = 1'b1;
				word.x.kind = x_spec.kind; // never none here
				word.x.addr = x_spec.addr;
			end
			if ((f & x_src_bit) != '0)
				word.b = x_spec;
			word.y = y;
			word.z = z;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			up    <= 1'b0;
		end else begin
			up <= 1'b1;
			if (load)
				state <= marginal ? st_grow : st_full;
			else if (out_ready)
				state <= st_idle; // drained with nothing behind
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			ctl <= word; // reloads on the same edge it drains
	end

	// a stalled word stays put until taken
	a_ctl_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(ctl))
		else $error("control word changed while stalled");

	// after an incrl the same fetch must still be offered
	a_fetch_held: assert property (@(posedge clk) disable iff (rst)
		state == st_grow |-> in_valid && $stable(head))
		else $error("fetch dropped or changed during incrl insertion");

endmodule

// File: logic/inst_decoder.sv
// dispatch-stage instruction decoder top
// classifier, Y/Z operand decoder, rL counter and dispatch FSM
`timescale 1ns/1ps

module inst_decoder
	import decode_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  fetch_t     head,
	input  logic       in_valid,
	output logic       in_ready,
	input  logic [7:0] g,
	input  logic [7:0] o,
	output logic [7:0] l,
	output control_t   ctl,
	output logic       out_valid,
	input  logic       out_ready
);

	mmix_opcode   op;
	internal_op_t i;
	flags_t       f;
	spec_t        y;
	spec_t        z;
	logic         grow; // one incrl issued

	assign op = mmix_opcode'(head.inst[31:24]);

	op_classifier u_cls (
		.op (op),
		.i  (i),
		.f  (f)
	);

	yz_operand_decoder u_yz (
		.head (head),
		.f    (f),
		.g    (g),
		.l    (l),
		.o    (o),
		.y    (y),
		.z    (z)
	);

	local_count u_rl (
		.clk (clk),
		.rst (rst),
		.inc (grow),
		.g   (g),
		.l   (l)
	);

	dispatch_fsm u_fsm (
		.clk       (clk),
		.rst       (rst),
		.head      (head),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.i         (i),
		.f         (f),
		.y         (y),
		.z         (z),
		.g         (g),
		.l         (l),
		.o         (o),
		.grow      (grow),
		.ctl       (ctl),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

// File: logic/local_count.sv
// rL counter
// grows by one per inserted incrl word
`timescale 1ns/1ps

module local_count (
	input  logic       clk,
	input  logic       rst,
	input  logic       inc,
	input  logic [7:0] g,
	output logic [7:0] l
);

	always_ff @(posedge clk) begin
		if (rst)
			l <= 8'd0;
		else if (inc)
			l <= l + 8'd1; // new rL seen the cycle after the pulse
	end

	// rL may never pass rG, the FSM only grows toward a marginal X
	a_l_below_g: assert property (@(posedge clk) disable iff (rst) inc |-> l != g)
		else $error("rL grown past rG");

endmodule

// File: logic/op_classifier.sv
// opcode classifier
// maps an MMIX opcode to its internal op and operand flags
// opcodes outside the kept groups decode as TRAP
`timescale 1ns/1ps

module op_classifier
	import decode_pkg::*;
(
	input  mmix_opcode   op,
	output internal_op_t i,
	output flags_t       f
);

	localparam flags_t trap_flags = y_reg_bit | z_reg_bit; // TRAP reads Y and Z

	flags_t zf;  // odd opcodes take Z as immediate
	flags_t xyz; // usual three-operand form

	assign zf  = op[0] ? z_imm_bit : z_reg_bit;
	assign xyz = x_dest_bit | y_reg_bit | zf;

	always_comb begin
		i = trap;
		f = trap_flags;
		case (op) inside
			[op_add:op_subui]: begin
				f = xyz;
				case (op[2:1])
					2'd0: i = add;
					2'd1: i = addu;
					2'd2: i = sub;
					default: i = subu;
				endcase
			end
			[op_cmp:op_cmpui]: begin
				f = xyz;
				i = op[1] ? cmpu : cmp;
			end
			[op_neg:op_negui]: begin
				f = x_dest_bit | y_imm_bit | zf; // Y is the constant minuend
				i = op[1] ? subu : sub;
			end
			[op_sl:op_srui]: begin
				f = xyz;
				case (op[2:1])
					2'd0: i = shl;
					2'd1: i = shlu;
					2'd2: i = shr;
					default: i = shru;
				endcase
			end
			[op_bn:op_bevb]: begin
				f = x_src_bit | rel_addr_bit; // X is the tested register
				i = br;
			end
			[op_pbn:op_pbevb]: begin
				f = x_src_bit | rel_addr_bit;
				i = pbr;
			end
			[op_or:op_nxori]: begin
				f = xyz;
				case (op[3:1])
					3'd0: i = or_;
					3'd1: i = orn;
					3'd2: i = nor_;
					3'd3: i = xor_;
					3'd4: i = and_;
					3'd5: i = andn;
					3'd6: i = nand_;
					default: i = nxor;
				endcase
			end
			[op_seth:op_setl]: begin
				f = x_dest_bit; // wyde goes straight into X
				i = set;
			end
			[op_inch:op_incl]: begin
				f = x_dest_bit | x_src_bit;
				i = addu;
			end
			[op_orh:op_orl]: begin
				f = x_dest_bit | x_src_bit;
				i = or_;
			end
			[op_andnh:op_andnl]: begin
				f = x_dest_bit | x_src_bit;
				i = andn;
			end
			op_jmp, op_jmpb: begin
				f = rel_addr_bit;
				i = jmp;
			end
			default: ; // unsupported, stays TRAP
		endcase
	end

endmodule

// File: logic/yz_operand_decoder.sv
// Y and Z operand decoder
// relative branch and jump targets, wyde constants of E0..EF
// immediate or register operand specs by the register rule
`timescale 1ns/1ps

module yz_operand_decoder
	import decode_pkg::*;
(
	input  fetch_t     head,
	input  flags_t     f,
	input  logic [7:0] g,
	input  logic [7:0] l,
	input  logic [7:0] o,
	output spec_t      y,
	output spec_t      z
);

	logic [7:0]  op;
	logic [7:0]  yy;
	logic [7:0]  zz;
	logic [15:0] yz;      // wyde / branch offset field
	logic [63:0] rel_off; // target offset in bytes
	logic        is_jmp;

	assign op = head.inst[31:24];
	assign yy = head.inst[15:8];
	assign zz = head.inst[7:0];
	assign yz = head.inst[15:0];

	assign is_jmp = {op[7:1], 1'b0} == op_jmp;

	// backward forms are the odd opcodes, so op[0] is the sign
	assign rel_off = is_jmp ? {{38{op[0]}}, head.inst[23:0], 2'b00}
	                        : {{46{op[0]}}, yz, 2'b00};

	always_comb begin
		y = '0;
		z = '0;
		if ((f & rel_addr_bit) != '0) begin
			y.value = head.loc + 64'd4; // return / fall-through address
			z.value = head.loc + rel_off;
		end else begin
			if (op[7:4] == 4'he)
				z.value = {48'd0, yz} << {~op[1:0], 4'h0}; // H, MH, ML, L
			else if ((f & z_imm_bit) != '0)
				z.value = {56'd0, zz};
			else if ((f & z_reg_bit) != '0)
				z = reg_spec(zz, g, l, o);

			if ((f & y_imm_bit) != '0)
				y.value = {56'd0, yy};
			else if ((f & y_reg_bit) != '0)
				y = reg_spec(yy, g, l, o);
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_inst_decoder -o sim_tb || exit 1
out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -q "Verification passed" && exit 0 || exit 1

// File: test/decode_checker.sv
// checker for the decoder output side
// models rL and the incrl words ahead of each marginal destination
// compares each real control word with the expected columns of the data file
`timescale 1ns/1ps

module decode_checker
	import decode_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] l,
	input  control_t   ctl,
	input  logic       out_valid,
	input  logic       out_ready,
	output int         tests_done,
	output int         errors
);

	int              fd;
	int              pending;   // incrl words still due before the real one
	int              test_errs;
	logic            have;      // a test record is loaded
	logic            held;      // last edge saw a stalled word
	logic [7:0]      lm = 8'd0; // rL model
	control_t        prev;
	control_t        exp_w;
	logic [8*16-1:0] name;
	logic [7:0]      tg;
	logic [7:0]      to_;
	logic [31:0]     tinst;
	logic [63:0]     tloc;
	logic [7:0]      ei;
	logic [1:0]      exk, ebk, eyk, ezk;
	logic [7:0]      exa, eba, eya, eza;
	logic [63:0]     eyv, ezv;

	task automatic load_next();
		int xr;
		have = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h\n", name, tg, to_,
			tinst, tloc, ei, exk, exa, ebk, eba, eyv, eyk, eya, ezv, ezk, eza) == 16;
		xr = int'(tinst[23:16]);
		pending = 0;
		if (have && exk != 2'd0 && xr >= int'(lm) && xr < int'(tg))
			pending = xr - int'(lm) + 1; // grow until X is local
		test_errs = 0;
	endtask

	task automatic take_word();
		exp_w = '0;
		exp_w.loc = tloc;
		if (pending > 0) begin
			exp_w.i       = incrl;
			exp_w.interim = 1'b1;
			exp_w.x       = '{ren: 1'b1, kind: src_local, addr: to_ + lm}; // wraps at 256
		end else begin
			exp_w.i = internal_op_t'(ei[4:0]);
			exp_w.x = '{ren: exk != 2'd0, kind: src_kind_t'(exk), addr: exa};
			exp_w.b = '{value: 64'd0, kind: src_kind_t'(ebk), addr: eba};
			exp_w.y = '{value: eyv, kind: src_kind_t'(eyk), addr: eya};
			exp_w.z = '{value: ezv, kind: src_kind_t'(ezk), addr: eza};
			if (l != lm) begin
				$display("error %0s: expected l %h actual %h", name, lm, l);
				test_errs++;
			end
		end
		if (ctl != exp_w) begin
			$display("error %0s: expected %h actual %h", name, exp_w, ctl);
			test_errs++;
		end
		if (pending > 0) begin
			pending--;
			lm = lm + 8'd1;
		end else begin
			$display("%0s %s", name, test_errs == 0 ? "ok" : "wrong");
			errors += test_errs;
			tests_done++;
			load_next();
		end
	endtask

	initial begin
		tests_done = 0;
		errors     = 0;
		held       = 1'b0;
		fd = $fopen("test/decode_testdata.txt", "r");
		load_next();
	end

	always @(posedge clk) begin
		if (!rst) begin
			if (held && !(out_valid && ctl == prev)) begin
				$display("stalled control word was changed or dropped");
				errors++;
			end
			held = out_valid && !out_ready;
			prev = ctl;
			if (out_valid && out_ready) begin
				if (have)
					take_word();
				else begin
					$display("control word arrived after the last test");
					errors++;
				end
			end
		end
	end

endmodule

// File: test/decode_testdata.txt
add_glob 20 00 20304050 1000 01 1 30 0 00 0 1 40 0 1 50
addi_imm 20 00 21312207 1004 01 1 31 0 00 0 1 22 7 0 00
grow3 20 10 24024050 1008 03 2 12 0 00 0 1 40 0 1 50
subu_loc 20 10 26010002 100c 04 2 11 0 00 0 2 10 0 2 12
add_wrap 20 fe 22020100 1010 02 2 00 0 00 0 2 ff 0 2 fe
cmp_marg 20 00 30010502 1014 05 2 01 0 00 0 0 00 0 2 02
cmpui 20 00 334001ff 1018 06 1 40 0 00 0 2 01 ff 0 00
neg 20 00 34010502 101c 03 2 01 0 00 5 0 00 0 2 02
negui 20 00 37010009 1020 04 2 01 0 00 0 0 00 9 0 00
sl 20 00 38300102 1024 07 1 30 0 00 0 2 01 0 2 02
srui 20 00 3f303103 1028 0a 1 30 0 00 0 1 31 3 0 00
or 20 00 c0300102 102c 0e 1 30 0 00 0 2 01 0 2 02
nxori 20 00 cf303107 1030 15 1 30 0 00 0 1 31 7 0 00
andn 20 00 ca300102 1034 13 1 30 0 00 0 2 01 0 2 02
xor_grow 20 00 c6044041 1038 11 2 04 0 00 0 1 40 0 1 41
seth 20 00 e0301234 103c 0d 1 30 0 00 0 0 00 1234000000000000 0 00
incml 20 00 e601abcd 1040 02 2 01 2 01 0 0 00 abcd0000 0 00
orl 20 00 eb3000ff 1044 0e 1 30 1 30 0 0 00 ff 0 00
andnmh 20 00 ed02beef 1048 13 2 02 2 02 0 0 00 beef00000000 0 00
bn_fwd 20 00 40010003 2000 0b 0 00 2 01 2004 0 00 200c 0 00
pbzb_back 20 00 5330fffe 2000 0c 0 00 1 30 2004 0 00 1ff8 0 00
jmp_fwd 20 00 f0000010 3000 16 0 00 0 00 3004 0 00 3040 0 00
jmpb 20 00 f1fffffc 3000 16 0 00 0 00 3004 0 00 2ff0 0 00
fadd_trap 20 00 04010203 4000 00 0 00 0 00 0 2 02 0 2 03
ldb_trap 20 00 80304050 4004 00 0 00 0 00 0 1 40 0 1 50
grow_wrap 20 fd 20064041 4008 01 2 03 0 00 0 1 40 0 1 41

// File: test/tb_inst_decoder.sv
// testbench top for the instruction decoder
// clock, reset, fetches read from the data file, random out_ready
// accept and drain waits with cycle timeouts, closing summary
`timescale 1ns/1ps

module tb_inst_decoder
	import decode_pkg::*;
();

	localparam int wait_limit = 2000; // cycles per wait, room for long incrl runs

	logic            clk;
	logic            rst;
	logic            in_valid;
	logic            in_ready;
	logic            out_valid;
	logic            out_ready;
	logic            timed_out;
	fetch_t          head;
	logic [7:0]      g;
	logic [7:0]      o;
	logic [7:0]      l;
	control_t        ctl;
	int              tests_done;
	int              errors;
	int              ntests;
	int              fd;
	int              waited;
	logic [31:0]     seed;
	logic [8*16-1:0] name;
	logic [7:0]      tg;
	logic [7:0]      to_;
	logic [31:0]     tinst;
	logic [63:0]     tloc;
	logic [63:0]     skip; // expected columns read by the checker

	inst_decoder uut (.clk(clk), .rst(rst), .head(head), .in_valid(in_valid),
		.in_ready(in_ready), .g(g), .o(o), .l(l), .ctl(ctl), .out_valid(out_valid),
		.out_ready(out_ready));

	decode_checker chk (.clk(clk), .rst(rst), .l(l), .ctl(ctl), .out_valid(out_valid),
		.out_ready(out_ready), .tests_done(tests_done), .errors(errors));

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		seed = 32'd60;
		forever begin
			@(posedge clk);
			#1;
			seed      = lcg_next(seed);
			out_ready = seed[16]; // roughly half the cycles stall
		end
	end

	initial begin
		rst       = 1'b1;
		in_valid  = 1'b0;
		head      = '0;
		g         = 8'd0;
		o         = 8'd0;
		out_ready = 1'b0;
		ntests    = 0;
		timed_out = 1'b0;
		fd = $fopen("test/decode_testdata.txt", "r");
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		while (!timed_out && $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h\n",
			name, tg, to_, tinst, tloc, skip, skip, skip, skip, skip, skip, skip, skip,
			skip, skip, skip) == 16) begin
			ntests++;
			head.loc  = tloc;
			head.inst = tinst;
			g         = tg;
			o         = to_;
			in_valid  = 1'b1;
			#2; // mid-cycle with out_ready settled
			waited = 0;
			while (!in_ready && !timed_out) begin
				@(posedge clk);
				#3;
				waited++;
				if (waited == wait_limit) begin
					$display("timeout: DUT never accepted fetch %0s", name);
					timed_out = 1'b1;
				end
			end
			@(posedge clk); // accept edge
			#1;
		end
		in_valid = 1'b0;
		waited   = 0;
		while (!timed_out && tests_done < ntests) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited == wait_limit) begin
				$display("timeout: only %0d of %0d real words came out", tests_done, ntests);
				timed_out = 1'b1;
			end
		end
		$display("tests %0d, done %0d, errors %0d", ntests, tests_done, errors);
		if (!timed_out && ntests > 0 && tests_done == ntests && errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
